// ==== include/seq_config.svh ====
`ifndef SEQ_CONFIG_SVH
`define SEQ_CONFIG_SVH

// Sequence field widths
`define SEQ_LL_BITS 17
`define SEQ_ML_BITS 17
`define SEQ_OFFSET_BITS 22

// Lanes per packet and lane index width
`define SEQ_PACKET_SIZE 4
`define SEQ_IDX_BITS 2

// Input buffering
`define SEQ_FIFO_DEPTH 8

// Sum of up to SEQ_PACKET_SIZE lengths needs SEQ_IDX_BITS of headroom
`define SEQ_TOTAL_BITS 19

// Lane count holds 0 to SEQ_PACKET_SIZE
`define SEQ_CNT_BITS 3

`endif

// ==== src/seq_fifo.sv ====
`include "seq_config.svh"

`default_nettype none

module seq_fifo
  import seq_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_valid,
  input  seq_entry_t i_entry,
  output logic       o_ready,
  output logic       o_valid,
  output seq_entry_t o_entry,
  input  logic       i_ready
);

  localparam int unsigned PTR_BITS = $clog2(`SEQ_FIFO_DEPTH);
  localparam int unsigned CNT_BITS = $clog2(`SEQ_FIFO_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(`SEQ_FIFO_DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(`SEQ_FIFO_DEPTH);

  seq_entry_t mem [0:`SEQ_FIFO_DEPTH-1];

  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [CNT_BITS-1:0] count_q;
  logic                push;
  logic                pop;

  assign o_ready = (count_q != FULL_CNT);
  assign o_valid = (count_q != '0);
  assign o_entry = mem[rd_ptr_q];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= i_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave occupancy alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/seq_pack_top.sv ====
`include "seq_config.svh"

`default_nettype none

module seq_pack_top
  import seq_pkg::*;
(
  input  logic                                      clk,
  input  logic                                      rst_n,

  input  logic                                      i_valid,
  input  seq_ll_t                                   i_ll,
  input  seq_ml_t                                   i_ml,
  input  seq_off_t                                  i_offset,
  input  logic                                      i_eoj,
  input  seq_ml_t                                   i_overlap_len,
  input  logic                                      i_delim,
  output logic                                      o_in_ready,

  output logic                                      o_valid,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_strb,
  output logic [`SEQ_PACKET_SIZE*`SEQ_LL_BITS-1:0]     o_ll,
  output logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     o_ml,
  output logic [`SEQ_PACKET_SIZE*`SEQ_OFFSET_BITS-1:0] o_offset,
  output logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     o_overlap,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_eoj,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_delim,
  output seq_cnt_t                                  o_count,
  output seq_total_t                                o_lit_total,
  output seq_total_t                                o_match_total,
  input  logic                                      i_ready
);

  // Packer to summer
  logic                                      pk_valid;
  logic                                      pk_ready;
  logic [`SEQ_PACKET_SIZE-1:0]               pk_strb;
  logic [`SEQ_PACKET_SIZE*`SEQ_LL_BITS-1:0]     pk_ll;
  logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     pk_ml;
  logic [`SEQ_PACKET_SIZE*`SEQ_OFFSET_BITS-1:0] pk_offset;
  logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     pk_overlap;
  logic [`SEQ_PACKET_SIZE-1:0]               pk_eoj;
  logic [`SEQ_PACKET_SIZE-1:0]               pk_delim;

  seq_packer u_packer (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (i_valid),
    .i_ll          (i_ll),
    .i_ml          (i_ml),
    .i_offset      (i_offset),
    .i_eoj         (i_eoj),
    .i_overlap_len (i_overlap_len),
    .i_delim       (i_delim),
    .o_ready       (o_in_ready),
    .o_valid       (pk_valid),
    .o_strb        (pk_strb),
    .o_ll          (pk_ll),
    .o_ml          (pk_ml),
    .o_offset      (pk_offset),
    .o_overlap     (pk_overlap),
    .o_eoj         (pk_eoj),
    .o_delim       (pk_delim),
    .i_ready       (pk_ready)
  );

  seq_packet_summer u_summer (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (pk_valid),
    .i_strb        (pk_strb),
    .i_ll          (pk_ll),
    .i_ml          (pk_ml),
    .i_offset      (pk_offset),
    .i_overlap     (pk_overlap),
    .i_eoj         (pk_eoj),
    .i_delim       (pk_delim),
    .o_ready       (pk_ready),
    .o_valid       (o_valid),
    .o_strb        (o_strb),
    .o_ll          (o_ll),
    .o_ml          (o_ml),
    .o_offset      (o_offset),
    .o_overlap     (o_overlap),
    .o_eoj         (o_eoj),
    .o_delim       (o_delim),
    .o_count       (o_count),
    .o_lit_total   (o_lit_total),
    .o_match_total (o_match_total),
    .i_ready       (i_ready)
  );

endmodule

`default_nettype wire

// ==== src/seq_packer.sv ====
`include "seq_config.svh"

`default_nettype none

module seq_packer
  import seq_pkg::*;
(
  input  logic                                      clk,
  input  logic                                      rst_n,

  input  logic                                      i_valid,
  input  seq_ll_t                                   i_ll,
  input  seq_ml_t                                   i_ml,
  input  seq_off_t                                  i_offset,
  input  logic                                      i_eoj,
  input  seq_ml_t                                   i_overlap_len,
  input  logic                                      i_delim,
  output logic                                      o_ready,

  output logic                                      o_valid,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_strb,
  output logic [`SEQ_PACKET_SIZE*`SEQ_LL_BITS-1:0]     o_ll,
  output logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     o_ml,
  output logic [`SEQ_PACKET_SIZE*`SEQ_OFFSET_BITS-1:0] o_offset,
  output logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     o_overlap,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_eoj,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_delim,
  input  logic                                      i_ready
);

  localparam logic [`SEQ_IDX_BITS-1:0] LAST_IDX = `SEQ_IDX_BITS'(`SEQ_PACKET_SIZE - 1);

  seq_entry_t in_entry;
  seq_entry_t head;
  logic       head_valid;
  logic       head_ready;
  logic       take;
  logic       close_pkt;

  packer_state_t               state_q;
  logic [`SEQ_IDX_BITS-1:0]    idx_q;
  logic [`SEQ_PACKET_SIZE-1:0] strb_q;
  logic [`SEQ_PACKET_SIZE-1:0] eoj_q;
  logic [`SEQ_PACKET_SIZE-1:0] delim_q;

  seq_ll_t  ll_q      [0:`SEQ_PACKET_SIZE-1];
  seq_ml_t  ml_q      [0:`SEQ_PACKET_SIZE-1];
  seq_off_t offset_q  [0:`SEQ_PACKET_SIZE-1];
  seq_ml_t  overlap_q [0:`SEQ_PACKET_SIZE-1];

  assign in_entry = '{
    ll:          i_ll,
    ml:          i_ml,
    offset:      i_offset,
    eoj:         i_eoj,
    overlap_len: i_overlap_len,
    delim:       i_delim
  };

  seq_fifo u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_valid (i_valid),
    .i_entry (in_entry),
    .o_ready (o_ready),
    .o_valid (head_valid),
    .o_entry (head),
    .i_ready (head_ready)
  );

  // FIFO is only drained while filling lanes
  assign head_ready = (state_q == S_LOAD);
  assign take       = head_valid && head_ready;
  assign close_pkt  = (idx_q == LAST_IDX) || head.eoj;

  // Lane payload
  always_ff @(posedge clk) begin
    if (take) begin
      ll_q[idx_q]      <= head.ll;
      ml_q[idx_q]      <= head.ml;
      offset_q[idx_q]  <= head.offset;
      overlap_q[idx_q] <= head.overlap_len;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_LOAD;
      idx_q   <= '0;
      strb_q  <= '0;
      eoj_q   <= '0;
      delim_q <= '0;
    end else begin
      case (state_q)
        S_LOAD: begin
          if (take) begin
            strb_q[idx_q]  <= 1'b1;
            eoj_q[idx_q]   <= head.eoj;
            delim_q[idx_q] <= head.delim;
            if (close_pkt) begin
              state_q <= S_FLUSH;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        S_FLUSH: begin
          // Clear lane flags once the packet is taken
          if (i_ready) begin
            state_q <= S_LOAD;
            idx_q   <= '0;
            strb_q  <= '0;
            eoj_q   <= '0;
            delim_q <= '0;
          end
        end
        default: state_q <= S_LOAD;
      endcase
    end
  end

  assign o_valid = (state_q == S_FLUSH);
  assign o_strb  = strb_q;
  assign o_eoj   = eoj_q;
  assign o_delim = delim_q;

  // Flatten lanes with lane 0 in the low bits
  for (genvar g = 0; g < `SEQ_PACKET_SIZE; g++) begin : g_lane
    assign o_ll[g*`SEQ_LL_BITS +: `SEQ_LL_BITS]             = ll_q[g];
    assign o_ml[g*`SEQ_ML_BITS +: `SEQ_ML_BITS]             = ml_q[g];
    assign o_offset[g*`SEQ_OFFSET_BITS +: `SEQ_OFFSET_BITS] = offset_q[g];
    assign o_overlap[g*`SEQ_ML_BITS +: `SEQ_ML_BITS]        = overlap_q[g];
  end

endmodule

`default_nettype wire

// ==== src/seq_packet_summer.sv ====
`include "seq_config.svh"

`default_nettype none

module seq_packet_summer
  import seq_pkg::*;
(
  input  logic                                      clk,
  input  logic                                      rst_n,

  input  logic                                      i_valid,
  input  logic [`SEQ_PACKET_SIZE-1:0]               i_strb,
  input  logic [`SEQ_PACKET_SIZE*`SEQ_LL_BITS-1:0]     i_ll,
  input  logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     i_ml,
  input  logic [`SEQ_PACKET_SIZE*`SEQ_OFFSET_BITS-1:0] i_offset,
  input  logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     i_overlap,
  input  logic [`SEQ_PACKET_SIZE-1:0]               i_eoj,
  input  logic [`SEQ_PACKET_SIZE-1:0]               i_delim,
  output logic                                      o_ready,

  output logic                                      o_valid,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_strb,
  output logic [`SEQ_PACKET_SIZE*`SEQ_LL_BITS-1:0]     o_ll,
  output logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     o_ml,
  output logic [`SEQ_PACKET_SIZE*`SEQ_OFFSET_BITS-1:0] o_offset,
  output logic [`SEQ_PACKET_SIZE*`SEQ_ML_BITS-1:0]     o_overlap,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_eoj,
  output logic [`SEQ_PACKET_SIZE-1:0]               o_delim,
  output seq_cnt_t                                  o_count,
  output seq_total_t                                o_lit_total,
  output seq_total_t                                o_match_total,
  input  logic                                      i_ready
);

  logic       valid_q;
  logic       load;
  seq_cnt_t   count_d;
  seq_total_t lit_d;
  seq_total_t match_d;

  // Register frees up in the same cycle it drains
  assign o_ready = !valid_q || i_ready;
  assign load    = i_valid && o_ready;

  // Popcount and strobe-masked sums
  always_comb begin
    count_d = '0;
    lit_d   = '0;
    match_d = '0;
    for (int i = 0; i < `SEQ_PACKET_SIZE; i++) begin
      if (i_strb[i]) begin
        count_d = count_d + 1'b1;
        lit_d   = lit_d + seq_total_t'(i_ll[i*`SEQ_LL_BITS +: `SEQ_LL_BITS]);
        match_d = match_d + seq_total_t'(i_ml[i*`SEQ_ML_BITS +: `SEQ_ML_BITS]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  // Packet and totals held until accepted downstream
  always_ff @(posedge clk) begin
    if (load) begin
      o_strb        <= i_strb;
      o_ll          <= i_ll;
      o_ml          <= i_ml;
      o_offset      <= i_offset;
      o_overlap     <= i_overlap;
      o_eoj         <= i_eoj;
      o_delim       <= i_delim;
      o_count       <= count_d;
      o_lit_total   <= lit_d;
      o_match_total <= match_d;
    end
  end

  assign o_valid = valid_q;

endmodule

`default_nettype wire

// ==== src/seq_pkg.sv ====
`include "seq_config.svh"

`default_nettype none

package seq_pkg;

  // Per-field types
  typedef logic [`SEQ_LL_BITS-1:0] seq_ll_t;
  typedef logic [`SEQ_ML_BITS-1:0] seq_ml_t;
  typedef logic [`SEQ_OFFSET_BITS-1:0] seq_off_t;

  // One sequence as it travels through the FIFO
  typedef struct packed {
    seq_ll_t  ll;
    seq_ml_t  ml;
    seq_off_t offset;
    logic     eoj;
    seq_ml_t  overlap_len;
    logic     delim;
  } seq_entry_t;

  // Per-packet totals
  typedef logic [`SEQ_TOTAL_BITS-1:0] seq_total_t;
  typedef logic [`SEQ_CNT_BITS-1:0] seq_cnt_t;

  // Packer FSM
  typedef enum logic {
    S_LOAD,
    S_FLUSH
  } packer_state_t;

endpackage

`default_nettype wire

// ==== tb/tb_seq_pack_top.sv ====
`include "seq_config.svh"

`default_nettype none

module tb_seq_pack_top
  import seq_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `SEQ_PACKET_SIZE;
  localparam int CLK_PERIOD = 10;
  localparam int N_FULL = 40;
  localparam int N_MIXED = 120;
  localparam int N_STALL = 80;
  localparam int DRAIN_CYCLES = 100;
  // 40 cycles per sequence plus reset and drain
  localparam int TIMEOUT_CYCLES = (N_FULL + N_MIXED + N_STALL) * 40 + 200;

  logic                          clk;
  logic                          rst_n;
  logic                          i_valid;
  seq_ll_t                       i_ll;
  seq_ml_t                       i_ml;
  seq_off_t                      i_offset;
  logic                          i_eoj;
  seq_ml_t                       i_overlap_len;
  logic                          i_delim;
  logic                          o_in_ready;
  logic                          o_valid;
  logic [N-1:0]                  o_strb;
  logic [N*`SEQ_LL_BITS-1:0]     o_ll;
  logic [N*`SEQ_ML_BITS-1:0]     o_ml;
  logic [N*`SEQ_OFFSET_BITS-1:0] o_offset;
  logic [N*`SEQ_ML_BITS-1:0]     o_overlap;
  logic [N-1:0]                  o_eoj;
  logic [N-1:0]                  o_delim;
  seq_cnt_t                      o_count;
  seq_total_t                    o_lit_total;
  seq_total_t                    o_match_total;
  logic                          i_ready;

  // Reference model state
  seq_entry_t  exp_q [$];
  seq_entry_t  cur;
  int unsigned sent;
  logic        in_xfer;
  logic        hold_active;
  logic        saw_full;
  logic [15:0] lfsr_q;
  string       test_name;

  // Packet seen under stall
  seq_entry_t held_lane [N];
  logic [N-1:0] held_strb;
  seq_cnt_t   held_count;
  seq_total_t held_lit;
  seq_total_t held_match;

  seq_pack_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic compare_entry(input string what, input seq_entry_t exp, input seq_entry_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_strb(input string what, input logic [N-1:0] exp, input logic [N-1:0] act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_count(input string what, input seq_cnt_t exp, input seq_cnt_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_total(input string what, input seq_total_t exp, input seq_total_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
      stop_on_failure();
    end
  endtask

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic seq_entry_t random_entry(input logic allow_eoj, input logic last);
    seq_entry_t e;
    e.ll = seq_ll_t'(rand_bits(`SEQ_LL_BITS));
    e.offset = seq_off_t'(rand_bits(`SEQ_OFFSET_BITS));
    e.overlap_len = seq_ml_t'(rand_bits(`SEQ_ML_BITS));
    e.delim = (rand_bits(3) == 0);
    // Block delimiters carry no match
    e.ml = e.delim ? '0 : seq_ml_t'(rand_bits(`SEQ_ML_BITS));
    e.eoj = allow_eoj && (last || (rand_bits(8) < 43));
    return e;
  endfunction

  function automatic seq_entry_t lane_entry(input int lane);
    seq_entry_t e;
    e.ll = o_ll[lane*`SEQ_LL_BITS +: `SEQ_LL_BITS];
    e.ml = o_ml[lane*`SEQ_ML_BITS +: `SEQ_ML_BITS];
    e.offset = o_offset[lane*`SEQ_OFFSET_BITS +: `SEQ_OFFSET_BITS];
    e.eoj = o_eoj[lane];
    e.overlap_len = o_overlap[lane*`SEQ_ML_BITS +: `SEQ_ML_BITS];
    e.delim = o_delim[lane];
    return e;
  endfunction

  task automatic check_idle();
    if (o_valid !== 1'b0 || o_in_ready !== 1'b1) begin
      $display("ERROR %s: expected o_valid=0 o_in_ready=1 actual o_valid=%b o_in_ready=%b",
               test_name, o_valid, o_in_ready);
      stop_on_failure();
    end
  endtask

  // Pops the next expected packet off the model queue and checks the outputs
  task automatic check_packet();
    seq_entry_t   e;
    logic [N-1:0] exp_strb;
    logic [N-1:0] exp_eoj;
    logic [N-1:0] exp_delim;
    seq_cnt_t     exp_count;
    seq_total_t   exp_lit;
    seq_total_t   exp_match;
    logic         closed;
    exp_strb = '0;
    exp_eoj = '0;
    exp_delim = '0;
    exp_count = '0;
    exp_lit = '0;
    exp_match = '0;
    closed = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (!closed && exp_q.size() == 0) begin
        $display("Output packet lane %0d has no accepted sequence behind it", i);
        stop_on_failure();
      end else if (!closed) begin
        e = exp_q.pop_front();
        compare_entry($sformatf("lane %0d", i), e, lane_entry(i));
        exp_strb[i] = 1'b1;
        exp_eoj[i] = e.eoj;
        exp_delim[i] = e.delim;
        exp_count = exp_count + 1'b1;
        exp_lit = exp_lit + seq_total_t'(e.ll);
        exp_match = exp_match + seq_total_t'(e.ml);
        closed = e.eoj || (i == N - 1);
      end
    end
    compare_strb("strobe", exp_strb, o_strb);
    compare_strb("eoj", exp_eoj, o_eoj);
    compare_strb("delim", exp_delim, o_delim);
    compare_count("count", exp_count, o_count);
    compare_total("literal total", exp_lit, o_lit_total);
    compare_total("match total", exp_match, o_match_total);
  endtask

  task automatic take_snapshot();
    for (int i = 0; i < N; i++) begin
      held_lane[i] = lane_entry(i);
    end
    held_strb = o_strb;
    held_count = o_count;
    held_lit = o_lit_total;
    held_match = o_match_total;
  endtask

  task automatic check_hold();
    if (!o_valid) begin
      $display("o_valid dropped before the stalled packet was accepted");
      stop_on_failure();
    end
    for (int i = 0; i < N; i++) begin
      compare_entry($sformatf("held lane %0d", i), held_lane[i], lane_entry(i));
    end
    compare_strb("held strobe", held_strb, o_strb);
    compare_count("held count", held_count, o_count);
    compare_total("held literal total", held_lit, o_lit_total);
    compare_total("held match total", held_match, o_match_total);
  endtask

  // Records transfers, drives inputs and checks the output at a falling edge
  task automatic service_cycle(input int unsigned target, input logic allow_eoj,
                               input int ready_mode);
    if (in_xfer) begin
      exp_q.push_back(cur);
      sent++;
    end
    if (!i_valid || in_xfer) begin
      if (sent < target && rand_bits(2) != 0) begin
        cur = random_entry(allow_eoj, sent + 1 == target);
        i_ll = cur.ll;
        i_ml = cur.ml;
        i_offset = cur.offset;
        i_eoj = cur.eoj;
        i_overlap_len = cur.overlap_len;
        i_delim = cur.delim;
        i_valid = 1'b1;
      end else begin
        i_valid = 1'b0;
      end
    end
    in_xfer = i_valid && o_in_ready;
    if (!o_in_ready) begin
      saw_full = 1'b1;
    end
    if (hold_active) begin
      check_hold();
    end
    case (ready_mode)
      0: i_ready = 1'b1;
      1: i_ready = (rand_bits(2) != 0);
      default: i_ready = 1'b0;
    endcase
    hold_active = o_valid && !i_ready;
    if (o_valid && i_ready) begin
      check_packet();
    end else if (o_valid) begin
      take_snapshot();
    end
  endtask

  task automatic run_phase(input string name, input int unsigned n, input logic allow_eoj,
                           input int unsigned stall_cycles, input int ready_mode);
    int unsigned target;
    int unsigned cyc;
    test_name = name;
    target = sent + n;
    cyc = 0;
    while (sent < target) begin
      @(negedge clk);
      service_cycle(target, allow_eoj, (cyc < stall_cycles) ? 2 : ready_mode);
      cyc++;
    end
  endtask

  // Output always ready until the model queue empties, then a quiet window
  task automatic drain_outputs(input int unsigned max_cycles);
    int unsigned cyc;
    test_name = "drain";
    cyc = 0;
    while (exp_q.size() != 0 && cyc < max_cycles) begin
      @(negedge clk);
      service_cycle(sent, 1'b0, 0);
      cyc++;
    end
    repeat (10) begin
      @(negedge clk);
      service_cycle(sent, 1'b0, 0);
    end
  endtask

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Run timed out with packets outstanding, %0d sequences never left the DUT",
             exp_q.size());
    stop_on_failure();
  end

  initial begin
    rst_n = 1'b0;
    i_valid = 1'b0;
    i_ll = '0;
    i_ml = '0;
    i_offset = '0;
    i_eoj = 1'b0;
    i_overlap_len = '0;
    i_delim = 1'b0;
    i_ready = 1'b0;
    lfsr_q = 16'd23;
    sent = 0;
    in_xfer = 1'b0;
    hold_active = 1'b0;
    saw_full = 1'b0;
    test_name = "reset";
    repeat (5) begin
      @(negedge clk);
      check_idle();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    run_phase("full_packets", N_FULL, 1'b0, 0, 0);
    run_phase("early_close", N_MIXED, 1'b1, 0, 1);
    saw_full = 1'b0;
    // Long stall first so the FIFO, packer and summer all fill
    run_phase("back_pressure", N_STALL, 1'b1, 60, 1);
    if (!saw_full) begin
      $display("o_in_ready never fell while the output was stalled");
      stop_on_failure();
    end
    drain_outputs(DRAIN_CYCLES);
    if (exp_q.size() != 0) begin
      $display("Model still holds %0d sequences at the end of the run", exp_q.size());
      stop_on_failure();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/seq_pkg.sv
src/seq_fifo.sv
src/seq_packer.sv
src/seq_packet_summer.sv
src/seq_pack_top.sv
tb/tb_seq_pack_top.sv
